//--- common/vstu_cfg_pkg.sv
// Sizing constants of the vector store unit, imported by every RTL file that needs a width
package vstu_cfg_pkg;

  //////////////////////////////
  // Lanes and beats
  //////////////////////////////

  // Lanes feeding the store unit
  localparam int unsigned NrLanes   = 2;
  // One lane word
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned LaneBytes = ElenWidth / 8;
  // A write beat carries one full register-file word
  localparam int unsigned BeatBytes = NrLanes * LaneBytes;
  // Byte count of one beat, 0 to BeatBytes inclusive
  localparam int unsigned BeatByteCntWidth = $clog2(BeatBytes) + 1;

  //////////////////////////////
  // Instruction tracking
  //////////////////////////////

  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned QueuePtrWidth = $clog2(QueueDepth);
  localparam int unsigned QueueCntWidth = QueuePtrWidth + 1;
  localparam int unsigned NrVInsn       = 8;
  localparam int unsigned VlWidth       = 10;
  // vl shifted by the largest vsew still fits
  localparam int unsigned ByteCntWidth  = 14;
  // Burst length field, beats minus one
  localparam int unsigned BurstLenWidth = 8;

endpackage

//--- common/vstu_txn_pkg.sv
// Transaction types exchanged between the store unit and its neighbours
package vstu_txn_pkg;

  import vstu_cfg_pkg::*;

  // One lane word and its byte mask
  typedef logic [ElenWidth-1:0] elen_t;
  typedef logic [LaneBytes-1:0] strb_t;

  // Instruction id
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Store instruction from the sequencer
  typedef struct packed {
    vid_t               id;
    logic [VlWidth-1:0] vl;
    // Element size as log2 of bytes
    logic [1:0]         vsew;
    // Set means unmasked
    logic               vm;
  } store_req_t;

  // Burst request from the address generator
  typedef struct packed {
    logic [BurstLenWidth-1:0] len;
    logic                     is_load;
  } burst_req_t;

  // One beat on the write data channel
  typedef struct packed {
    logic [BeatBytes*8-1:0] data;
    logic [BeatBytes-1:0]   strb;
    logic                   last;
  } w_beat_t;

  // One done bit per instruction id
  typedef logic [NrVInsn-1:0] resp_t;

endpackage

//--- design/operand_spill.sv
// One-slot fall-through register, placed between a lane and the store unit for operands or masks
`timescale 1ns/1ps

module operand_spill #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Producer side
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  // Consumer side
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  T     data_q;
  logic full_q;

  // Slot free means the producer may hand over a word
  assign ready_o = !full_q;

  // Held word first, otherwise input falls straight through
  assign valid_o = full_q || valid_i;
  assign data_o  = full_q ? data_q : data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Held word taken by the consumer
      if (ready_i) full_q <= 1'b0;
    end else if (valid_i && !ready_i) begin
      full_q <= 1'b1;
    end
  end

  // Capture only when the word cannot fall through this cycle
  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i && !ready_i) begin
      data_q <= data_i;
    end
  end

endmodule

//--- design/vstu_top.sv
// Vector store unit top level connecting lane spill registers, queue, control and beat packer
`timescale 1ns/1ps

module vstu_top
  import vstu_cfg_pkg::*;
  import vstu_txn_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  // Sequencer
  input  store_req_t          req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  // Lanes
  input  elen_t [NrLanes-1:0] operand_i,
  input  logic  [NrLanes-1:0] operand_valid_i,
  output logic  [NrLanes-1:0] operand_ready_o,
  // Mask unit
  input  strb_t [NrLanes-1:0] mask_i,
  input  logic  [NrLanes-1:0] mask_valid_i,
  output logic                mask_ready_o,
  // Address generator
  input  burst_req_t          burst_i,
  input  logic                burst_valid_i,
  output logic                burst_ready_o,
  // Memory write data
  output w_beat_t             w_o,
  output logic                w_valid_o,
  input  logic                w_ready_i,
  // Memory write response
  input  logic                b_valid_i,
  output logic                b_ready_o,
  // Status
  output logic                store_pending_o,
  output logic                store_complete_o,
  output resp_t               resp_o
);

  elen_t [NrLanes-1:0]         lane_operand;
  logic  [NrLanes-1:0]         lane_operand_valid;
  strb_t [NrLanes-1:0]         lane_mask;
  logic  [NrLanes-1:0]         lane_mask_valid;
  logic  [NrLanes-1:0]         spill_pop;
  store_req_t                  issue_req;
  logic                        issue_valid;
  logic                        issue_pop;
  vid_t                        commit_id;
  logic                        commit_valid;
  logic                        commit_pop;
  logic [QueueCntWidth-1:0]    pending_issue;
  logic                        last;
  logic [BeatByteCntWidth-1:0] beat_bytes;
  logic [ByteCntWidth-1:0]     remaining;

  //////////////////////////////
  // Lane spill registers
  //////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_spill
    operand_spill #(.T(elen_t)) i_operand_spill (
      .clk_i, .rst_ni,
      .data_i  (operand_i[l]),
      .valid_i (operand_valid_i[l]),
      .ready_o (operand_ready_o[l]),
      .data_o  (lane_operand[l]),
      .valid_o (lane_operand_valid[l]),
      .ready_i (spill_pop[l])
    );

    // Mask unit holds its word until the mask pulse
    operand_spill #(.T(strb_t)) i_mask_spill (
      .clk_i, .rst_ni,
      .data_i  (mask_i[l]),
      .valid_i (mask_valid_i[l]),
      .ready_o (),
      .data_o  (lane_mask[l]),
      .valid_o (lane_mask_valid[l]),
      .ready_i (mask_ready_o)
    );
  end

  //////////////////////////////
  // Queue, control, packer
  //////////////////////////////

  vstu_insn_queue i_insn_queue (
    .clk_i, .rst_ni, .req_i, .req_valid_i, .req_ready_o,
    .issue_req_o     (issue_req),
    .issue_valid_o   (issue_valid),
    .issue_pop_i     (issue_pop),
    .commit_id_o     (commit_id),
    .commit_valid_o  (commit_valid),
    .commit_pop_i    (commit_pop),
    .pending_issue_o (pending_issue),
    .store_pending_o
  );

  vstu_ctrl i_ctrl (
    .clk_i, .rst_ni,
    .issue_req_i     (issue_req),
    .issue_valid_i   (issue_valid),
    .issue_pop_o     (issue_pop),
    .commit_id_i     (commit_id),
    .commit_valid_i  (commit_valid),
    .commit_pop_o    (commit_pop),
    .pending_issue_i (pending_issue),
    .operand_valid_i (lane_operand_valid),
    .mask_valid_i    (lane_mask_valid),
    .spill_pop_o     (spill_pop),
    .mask_ready_o, .burst_i, .burst_valid_i, .burst_ready_o, .w_ready_i, .w_valid_o,
    .last_o          (last),
    .beat_bytes_i    (beat_bytes),
    .remaining_o     (remaining),
    .b_valid_i, .b_ready_o, .store_complete_o, .resp_o
  );

  vstu_w_packer i_w_packer (
    .operand_i    (lane_operand),
    .mask_i       (lane_mask),
    .vm_i         (issue_req.vm),
    .remaining_i  (remaining),
    .last_i       (last),
    .w_o,
    .beat_bytes_o (beat_bytes)
  );

endmodule

//--- test/tb_vstu_table.svh
// Store table for the vector store unit testbench, one row per instruction in issue order

// Columns are id, vl, vsew, vm, burst len (beats minus one)
// Byte count is vl << vsew, burst covers ceil(bytes / 16) beats
typedef struct packed {
  logic [2:0] id;
  logic [9:0] vl;
  logic [1:0] vsew;
  logic       vm;
  logic [7:0] len;
} row_t;

localparam int NrRows = 8;

localparam row_t StoreTable [NrRows] = '{
  '{3'd0, 10'd16, 2'd0, 1'b1, 8'd0},  // one full beat
  '{3'd1, 10'd8,  2'd3, 1'b1, 8'd3},  // 64 bytes
  '{3'd2, 10'd10, 2'd1, 1'b1, 8'd1},  // 20 bytes, partial tail
  '{3'd3, 10'd12, 2'd2, 1'b0, 8'd2},  // masked, 48 bytes
  '{3'd4, 10'd5,  2'd0, 1'b0, 8'd0},  // masked, 5 bytes
  '{3'd5, 10'd32, 2'd2, 1'b1, 8'd7},  // 128 bytes, long burst
  '{3'd6, 10'd7,  2'd3, 1'b0, 8'd3},  // masked, half tail beat
  '{3'd7, 10'd3,  2'd1, 1'b1, 8'd0}   // 6 bytes
};

//--- test/tb_vstu_top.sv
// Testbench for the vector store unit, runs the store table through lane, address and memory models
`timescale 1ns/1ps

module tb_vstu_top
  import vstu_cfg_pkg::*;
  import vstu_txn_pkg::*;
();

  `include "tb_vstu_table.svh"

  localparam int MaxBeats      = 64;
  localparam int TimeoutCycles = 2000;

  logic                clk_i;
  logic                rst_ni;
  store_req_t          req_i;
  logic                req_valid_i;
  logic                req_ready_o;
  elen_t [NrLanes-1:0] operand_i;
  logic  [NrLanes-1:0] operand_valid_i;
  logic  [NrLanes-1:0] operand_ready_o;
  strb_t [NrLanes-1:0] mask_i;
  logic  [NrLanes-1:0] mask_valid_i;
  logic                mask_ready_o;
  burst_req_t          burst_i;
  logic                burst_valid_i;
  logic                burst_ready_o;
  w_beat_t             w_o;
  logic                w_valid_o;
  logic                w_ready_i;
  logic                b_valid_i;
  logic                b_ready_o;
  logic                store_pending_o;
  logic                store_complete_o;
  resp_t               resp_o;

  // Per-beat stimulus, indexed by global beat number
  elen_t lane_word [MaxBeats][NrLanes];
  strb_t mask_word [MaxBeats][NrLanes];
  int    beat_row  [MaxBeats];
  int    beat_idx  [MaxBeats];
  int    mask_of   [MaxBeats];
  int    total_beats;
  int    n_masked;
  int    seed;
  int    cycle;
  // Model progress
  int    beat_ptr;
  int    msk_ptr;
  int    op_ptr [NrLanes];
  int    n_req;
  int    n_burst;
  int    n_commit;
  int    outstanding;
  int    last_due;
  int    resp_due [$];
  resp_t exp_resp;
  logic  saw_full;

  vstu_top i_vstu_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Checking helpers
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  // Beat g built from the lane mapping and strobe rules
  function automatic w_beat_t expected_beat(input int g);
    w_beat_t beat;
    row_t    row;
    int      nbytes;
    beat   = '0;
    row    = StoreTable[beat_row[g]];
    nbytes = (int'(row.vl) << row.vsew) - int'(BeatBytes) * beat_idx[g];
    if (nbytes > int'(BeatBytes)) nbytes = int'(BeatBytes);
    beat.last = (beat_idx[g] == int'(row.len));
    for (int i = 0; i < nbytes; i++) begin
      beat.data[8*i +: 8] = lane_word[g][i / LaneBytes][8*(i % LaneBytes) +: 8];
      beat.strb[i] = row.vm || mask_word[mask_of[g]][i / LaneBytes][i % LaneBytes];
    end
    return beat;
  endfunction

  task automatic build_stimulus();
    row_t row;
    total_beats = 0;
    n_masked    = 0;
    for (int r = 0; r < NrRows; r++) begin
      row = StoreTable[r];
      for (int b = 0; b <= int'(row.len); b++) begin
        beat_row[total_beats] = r;
        beat_idx[total_beats] = b;
        mask_of[total_beats]  = row.vm ? 0 : n_masked;
        for (int l = 0; l < NrLanes; l++) begin
          lane_word[total_beats][l] = {$random(seed), $random(seed)};
          mask_word[n_masked][l]    = strb_t'($random(seed));
        end
        // Mask words only consumed by masked beats
        if (!row.vm) n_masked++;
        total_beats++;
      end
    end
  endtask

  //////////////////////////////
  // Neighbour models
  //////////////////////////////

  task automatic drive_inputs();
    row_t req_row;
    row_t burst_row;
    req_row   = StoreTable[(n_req < NrRows) ? n_req : 0];
    burst_row = StoreTable[(n_burst < NrRows) ? n_burst : 0];
    // Sequencer pushes the table as fast as the queue allows
    req_valid_i  = (n_req < NrRows);
    req_i.id     = req_row.id;
    req_i.vl     = req_row.vl;
    req_i.vsew   = req_row.vsew;
    req_i.vm     = req_row.vm;
    // Lanes and mask unit hold a word until it is taken
    for (int l = 0; l < NrLanes; l++) begin
      operand_valid_i[l] = (op_ptr[l] < total_beats);
      operand_i[l]       = lane_word[op_ptr[l]][l];
      mask_valid_i[l]    = (msk_ptr < n_masked);
      mask_i[l]          = mask_word[msk_ptr][l];
    end
    // One burst per store, in table order
    burst_valid_i   = (n_burst < NrRows);
    burst_i.len     = burst_row.len;
    burst_i.is_load = 1'b0;
    // Memory stalls about one cycle in four
    w_ready_i = (($random(seed) & 3) != 0);
    b_valid_i = (resp_due.size() > 0) && (resp_due[0] <= cycle);
  endtask

  // Sampled after inputs settle, so the coming edge is already decided
  task automatic check_and_advance();
    int                 cur;
    int                 due;
    row_t               row;
    logic               fire;
    logic               exp_last;
    logic [NrLanes-1:0] exp_op_ready;
    cur      = (beat_ptr < total_beats) ? beat_ptr : 0;
    row      = StoreTable[beat_row[cur]];
    fire     = w_valid_o && w_ready_i;
    exp_last = fire && (beat_idx[cur] == int'(row.len));
    check_value("req_ready_o", req_ready_o, outstanding != int'(QueueDepth));
    check_value("store_pending_o", store_pending_o, outstanding != 0);
    check_value("b_ready_o", b_ready_o, b_valid_i);
    check_value("store_complete_o", store_complete_o, b_valid_i);
    check_value("resp_o", resp_o, exp_resp);
    // Held beat must match the same expected beat until taken
    if (w_valid_o) begin
      if (beat_ptr >= total_beats) abort_run("write data offered after the final expected beat");
      check_value("w_o", w_o, expected_beat(beat_ptr));
    end
    check_value("burst_ready_o", burst_ready_o, exp_last);
    check_value("mask_ready_o", mask_ready_o, fire && !row.vm);
    // Lane side ready only while no handed-over word waits in its spill slot
    for (int l = 0; l < NrLanes; l++) begin
      exp_op_ready[l] = (op_ptr[l] == beat_ptr);
    end
    check_value("operand_ready_o", operand_ready_o, exp_op_ready);
    if (!req_ready_o) saw_full = 1'b1;

    if (fire) beat_ptr++;
    // Response a few cycles after the burst closes, kept in order
    if (exp_last) begin
      n_burst++;
      due = cycle + 3 + ($random(seed) & 3);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      resp_due.push_back(due);
    end
    for (int l = 0; l < NrLanes; l++) begin
      if (operand_valid_i[l] && operand_ready_o[l]) op_ptr[l]++;
    end
    if (mask_ready_o) msk_ptr++;
    if (req_valid_i && req_ready_o) begin
      n_req++;
      outstanding++;
    end
    // Done bit of the committed id shows on the next cycle
    exp_resp = '0;
    if (b_valid_i) begin
      exp_resp[StoreTable[n_commit].id] = 1'b1;
      n_commit++;
      outstanding--;
      void'(resp_due.pop_front());
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed            = 39;
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    mask_i          = '0;
    mask_valid_i    = '0;
    burst_i         = '0;
    burst_valid_i   = 1'b0;
    w_ready_i       = 1'b0;
    b_valid_i       = 1'b0;
    cycle           = 0;
    beat_ptr        = 0;
    msk_ptr         = 0;
    n_req           = 0;
    n_burst         = 0;
    n_commit        = 0;
    outstanding     = 0;
    last_due        = 0;
    exp_resp        = '0;
    saw_full        = 1'b0;
    for (int l = 0; l < NrLanes; l++) op_ptr[l] = 0;
    build_stimulus();

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    // Idle state out of reset
    check_value("w_valid_o", w_valid_o, 1'b0);
    check_value("store_pending_o", store_pending_o, 1'b0);
    check_value("store_complete_o", store_complete_o, 1'b0);
    check_value("resp_o", resp_o, '0);
    check_value("req_ready_o", req_ready_o, 1'b1);

    while (n_commit < NrRows) begin
      @(negedge clk_i);
      drive_inputs();
      #1;
      check_and_advance();
      cycle++;
      if (cycle >= TimeoutCycles) abort_run("timeout while waiting for all stores to commit");
    end

    // Last done bit and drained queue
    @(negedge clk_i);
    drive_inputs();
    #1;
    check_value("resp_o", resp_o, exp_resp);
    check_value("store_pending_o", store_pending_o, 1'b0);
    check_value("w_valid_o", w_valid_o, 1'b0);
    if (!saw_full) begin
      abort_run("req_ready_o never dropped while the queue held four stores");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- vstu_core/vstu_ctrl.sv
// Store unit control for beat firing, burst closing, issue advance and in-order commit
`timescale 1ns/1ps

module vstu_ctrl
  import vstu_cfg_pkg::*;
  import vstu_txn_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Instruction queue
  input  store_req_t                  issue_req_i,
  input  logic                        issue_valid_i,
  output logic                        issue_pop_o,
  input  vid_t                        commit_id_i,
  input  logic                        commit_valid_i,
  output logic                        commit_pop_o,
  input  logic [QueueCntWidth-1:0]    pending_issue_i,
  // Spill registers
  input  logic [NrLanes-1:0]          operand_valid_i,
  input  logic [NrLanes-1:0]          mask_valid_i,
  output logic [NrLanes-1:0]          spill_pop_o,
  output logic                        mask_ready_o,
  // Address generator
  input  burst_req_t                  burst_i,
  input  logic                        burst_valid_i,
  output logic                        burst_ready_o,
  // Write data channel
  input  logic                        w_ready_i,
  output logic                        w_valid_o,
  output logic                        last_o,
  // Packer
  input  logic [BeatByteCntWidth-1:0] beat_bytes_i,
  output logic [ByteCntWidth-1:0]     remaining_o,
  // Write response channel
  input  logic                        b_valid_i,
  output logic                        b_ready_o,
  output logic                        store_complete_o,
  output resp_t                       resp_o
);

  // Remaining bytes, valid once the head has fired a beat
  logic [ByteCntWidth-1:0]  rem_q;
  logic                     loaded_q;
  logic [ByteCntWidth-1:0]  rem_eff;
  logic [ByteCntWidth-1:0]  rem_next;
  // Beats already sent in the current burst
  logic [BurstLenWidth-1:0] beat_cnt_q;
  logic                     fire;
  resp_t                    resp_d;

  //////////////////////////////
  // Beat firing
  //////////////////////////////

  // Everything but memory readiness
  assign w_valid_o = issue_valid_i && burst_valid_i && !burst_i.is_load &&
                     (&operand_valid_i) && (issue_req_i.vm || (&mask_valid_i));
  assign fire      = w_valid_o && w_ready_i;

  // Lanes and mask unit consumed together
  assign spill_pop_o  = {NrLanes{fire}};
  assign mask_ready_o = fire && !issue_req_i.vm;

  // Burst closes on beat number len
  assign last_o        = (beat_cnt_q == burst_i.len);
  assign burst_ready_o = fire && last_o;

  //////////////////////////////
  // Issue advance
  //////////////////////////////

  // Fresh head takes its count straight from the queue
  assign rem_eff     = loaded_q ? rem_q :
                       (ByteCntWidth'(issue_req_i.vl) << issue_req_i.vsew);
  assign remaining_o = rem_eff;
  // Packer never reports more than what remains
  assign rem_next    = fire ? rem_eff - ByteCntWidth'(beat_bytes_i) : rem_eff;
  assign issue_pop_o = issue_valid_i && (rem_next == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q      <= '0;
      loaded_q   <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      // Next head or an empty issue phase reloads from the queue
      if (issue_pop_o || (pending_issue_i == '0)) begin
        loaded_q <= 1'b0;
      end else if (fire) begin
        loaded_q <= 1'b1;
      end
      if (fire) begin
        rem_q      <= rem_next;
        beat_cnt_q <= last_o ? '0 : beat_cnt_q + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Response and commit
  //////////////////////////////

  // Every response is taken, only one past issue commits
  assign b_ready_o        = b_valid_i;
  assign commit_pop_o     = b_valid_i && commit_valid_i;
  assign store_complete_o = commit_pop_o;

  always_comb begin
    resp_d = '0;
    if (commit_pop_o) resp_d[commit_id_i] = 1'b1;
  end

  // Done bit shows for one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_o <= '0;
    end else begin
      resp_o <= resp_d;
    end
  end

endmodule

//--- vstu_core/vstu_insn_queue.sv
// In-order store instruction queue tracking accept, issue and commit phases per slot
`timescale 1ns/1ps

module vstu_insn_queue
  import vstu_cfg_pkg::*;
  import vstu_txn_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Sequencer side
  input  store_req_t               req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  // Issue phase
  output store_req_t               issue_req_o,
  output logic                     issue_valid_o,
  input  logic                     issue_pop_i,
  // Commit phase
  output vid_t                     commit_id_o,
  output logic                     commit_valid_o,
  input  logic                     commit_pop_i,
  // Status
  output logic [QueueCntWidth-1:0] pending_issue_o,
  output logic                     store_pending_o
);

  // Slot storage
  store_req_t mem_q [QueueDepth];

  // One pointer per phase
  logic [QueuePtrWidth-1:0] accept_pnt_q;
  logic [QueuePtrWidth-1:0] issue_pnt_q;
  logic [QueuePtrWidth-1:0] commit_pnt_q;

  // Instructions still to issue, and still to commit
  logic [QueueCntWidth-1:0] issue_cnt_q;
  logic [QueueCntWidth-1:0] commit_cnt_q;

  logic full;
  logic accept;

  // Every accepted slot stays counted until commit
  assign full        = (commit_cnt_q == QueueCntWidth'(QueueDepth));
  assign req_ready_o = !full;
  assign accept      = req_valid_i && !full;

  // Head of the issue phase
  assign issue_req_o   = mem_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  // Commit head has left issue when more are awaiting commit than issue
  assign commit_id_o    = mem_q[commit_pnt_q].id;
  assign commit_valid_o = (commit_cnt_q > issue_cnt_q);

  assign pending_issue_o = issue_cnt_q;
  assign store_pending_o = (commit_cnt_q != '0);

  //////////////////////////////
  // Pointers and counters
  //////////////////////////////

  // Depth is a power of two, so pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) accept_pnt_q <= accept_pnt_q + 1'b1;
      if (issue_pop_i) issue_pnt_q <= issue_pnt_q + 1'b1;
      if (commit_pop_i) commit_pnt_q <= commit_pnt_q + 1'b1;
      // Accept and pop may meet in one cycle
      issue_cnt_q  <= issue_cnt_q + QueueCntWidth'(accept) - QueueCntWidth'(issue_pop_i);
      commit_cnt_q <= commit_cnt_q + QueueCntWidth'(accept) - QueueCntWidth'(commit_pop_i);
    end
  end

  // Slot write at the accept pointer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= req_i;
    end
  end

endmodule

//--- vstu_core/vstu_w_packer.sv
// Packs lane operand bytes into one write beat with strobes and a valid byte count
`timescale 1ns/1ps

module vstu_w_packer
  import vstu_cfg_pkg::*;
  import vstu_txn_pkg::*;
(
  input  elen_t [NrLanes-1:0]         operand_i,
  input  strb_t [NrLanes-1:0]         mask_i,
  input  logic                        vm_i,
  input  logic [ByteCntWidth-1:0]     remaining_i,
  input  logic                        last_i,
  output w_beat_t                     w_o,
  output logic [BeatByteCntWidth-1:0] beat_bytes_o
);

  // Valid bytes of this beat, capped at a full beat
  assign beat_bytes_o = (remaining_i < ByteCntWidth'(BeatBytes)) ?
                        BeatByteCntWidth'(remaining_i) : BeatByteCntWidth'(BeatBytes);

  always_comb begin
    int unsigned lane;
    int unsigned offset;

    w_o      = '0;
    w_o.last = last_i;
    // Sequential lane order, no element shuffle
    for (int unsigned i = 0; i < BeatBytes; i++) begin
      lane   = i / LaneBytes;
      offset = i % LaneBytes;
      // Bytes past the count stay zero
      if (i < beat_bytes_o) begin
        w_o.data[8*i +: 8] = operand_i[lane][8*offset +: 8];
        w_o.strb[i]        = vm_i || mask_i[lane][offset];
      end
    end
  end

endmodule

//--- vstu_top.f
+incdir+test
common/vstu_cfg_pkg.sv
common/vstu_txn_pkg.sv
design/operand_spill.sv
vstu_core/vstu_insn_queue.sv
vstu_core/vstu_ctrl.sv
vstu_core/vstu_w_packer.sv
design/vstu_top.sv
test/tb_vstu_top.sv
